//--- source/uart_line_pkg.sv
package uart_line_pkg;

	//////////////////////////////
	// Serial frame format
	//////////////////////////////

	// Parity mode as written by CFG_FRAME bits 1:0
	typedef enum logic [1:0] {
		PARITY_NONE = 2'd0,	// 8N
		PARITY_EVEN = 2'd1,	// Even count of ones incl. parity bit
		PARITY_ODD  = 2'd2	// Odd count of ones incl. parity bit
	} parity_e;

	//////////////////////////////
	// Serializer FSM
	//////////////////////////////

	// One state per frame section, each held for divisor clocks per bit
	typedef enum logic [2:0] {
		SER_IDLE   = 3'd0,	// Line high, waiting for start strobe
		SER_START  = 3'd1,	// Start bit, line low
		SER_DATA   = 3'd2,	// 8 data bits, LSB first
		SER_PARITY = 3'd3,	// Optional parity bit
		SER_STOP   = 3'd4	// 1 or 2 stop bits, line high
	} ser_state_e;

	//////////////////////////////
	// Baud rate
	//////////////////////////////

	// Clocks per bit after reset
	localparam logic [15:0] DEFAULT_DIV = 16'd100;

	// Smallest divisor the config block accepts
	localparam logic [15:0] MIN_DIV = 16'd4;

endpackage

//--- source/uart_queue_pkg.sv
package uart_queue_pkg;

	//////////////////////////////
	// Config interface
	//////////////////////////////

	// Opcode that comes with i_cfg_wr
	typedef enum logic [1:0] {
		CFG_BAUD_DIV = 2'd0,	// Data 15:0 -> divisor
		CFG_FRAME    = 2'd1,	// Data 1:0 parity, data 2 two stop bits
		CFG_FLUSH    = 2'd2	// Drop everything queued
	} cfg_op_e;

	//////////////////////////////
	// Queue controller FSM
	//////////////////////////////

	typedef enum logic [1:0] {
		Q_IDLE = 2'd0,	// Waiting for FIFO data
		Q_WAIT = 2'd1,	// Frame in flight, wait for busy to fall
		Q_DONE = 2'd2	// One spacer cycle before next pop
	} queue_state_e;

	// Bytes per FIFO word, low byte goes out first
	localparam int BYTES_PER_WORD = 4;

endpackage

//--- source/word_byte_fifo.sv
module word_byte_fifo #(
	parameter int FIFO_WORDS  = 8,	// Depth in 32-bit words
	parameter int PFULL_WORDS = 6	// Programmable full threshold in words
)(
	input  logic        i_sys_clk,
	input  logic        i_reset_n,

	input  logic        i_wr,		// Word write strobe
	input  logic [31:0] i_wr_data,
	input  logic        i_rd,		// Byte pop strobe
	input  logic        i_flush,	// Drop all queued words

	output logic [7:0]  o_rd_data,	// Head byte
	output logic        o_empty,
	output logic        o_pfull,
	output logic        o_overflow	// Write dropped, one-cycle pulse
);

	localparam int AW = $clog2(FIFO_WORDS);

	// Limits sized to the word counter
	localparam logic [AW:0]   FULL_LIM  = FIFO_WORDS[AW:0];
	localparam logic [AW:0]   PFULL_LIM = PFULL_WORDS[AW:0];
	localparam logic [AW-1:0] LAST_IDX  = AW'(FIFO_WORDS - 1);

	logic [31:0]   mem [FIFO_WORDS];	// Word storage

	// Pointers carry a phase bit on top of the slot index
	logic [AW:0]   wr_ptr;
	logic [AW:0]   rd_ptr;
	logic [1:0]    byte_idx;	// Byte within head word
	logic [AW:0]   word_cnt;	// Words with at least one unsent byte
	logic          full;
	logic          wr_ok;
	logic          rd_ok;

	//////////////////////////////
	// Flags
	//////////////////////////////

	// Same phase -> plain difference, else wrapped once
	always_comb begin
		if (wr_ptr[AW] == rd_ptr[AW])
			word_cnt = {1'b0, wr_ptr[AW-1:0]} - {1'b0, rd_ptr[AW-1:0]};
		else
			word_cnt = FULL_LIM - {1'b0, rd_ptr[AW-1:0]} + {1'b0, wr_ptr[AW-1:0]};
	end

	assign full    = (word_cnt == FULL_LIM);
	assign o_empty = (wr_ptr == rd_ptr);		// Read side empties only on 4th byte
	assign o_pfull = (word_cnt >= PFULL_LIM);

	assign wr_ok = i_wr & ~full;
	assign rd_ok = i_rd & ~o_empty & ~i_flush;	// Flush wins over pop

	// Head byte, low byte first
	assign o_rd_data = mem[rd_ptr[AW-1:0]][8*byte_idx +: 8];

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge i_sys_clk) begin
		if (wr_ok)
			mem[wr_ptr[AW-1:0]] <= i_wr_data;
	end

	//////////////////////////////
	// Pointers
	//////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			byte_idx   <= 2'd0;
			o_overflow <= 1'b0;
		end else begin
			o_overflow <= i_wr & full;	// Dropped word
			// Write side, wrap and flip phase at the last slot
			if (wr_ok) begin
				if (wr_ptr[AW-1:0] == LAST_IDX)
					wr_ptr <= {~wr_ptr[AW], {AW{1'b0}}};
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (i_flush) begin
				rd_ptr   <= wr_ptr;	// Word written this cycle survives
				byte_idx <= 2'd0;
			end else if (rd_ok) begin
				byte_idx <= byte_idx + 2'd1;	// Wraps to 0 after byte 3
				// Head word done after its 4th byte
				if (byte_idx == 2'd3) begin
					if (rd_ptr[AW-1:0] == LAST_IDX)
						rd_ptr <= {~rd_ptr[AW], {AW{1'b0}}};
					else
						rd_ptr <= rd_ptr + 1'b1;
				end
			end
		end
	end

endmodule

//--- source/uart_tx_queue.sv
module uart_tx_queue (
	input  logic       i_sys_clk,
	input  logic       i_reset_n,

	input  logic       i_fifo_empty,
	input  logic [7:0] i_fifo_data,	// FIFO head byte
	input  logic       i_tx_busy,	// Serializer busy

	output logic       o_fifo_pop,	// Advance FIFO head
	output logic       o_tx_start,	// Start one frame
	output logic [7:0] o_tx_data
);

	uart_queue_pkg::queue_state_e state;

	logic busy_d;		// Busy one cycle ago
	logic busy_fall;

	// Frame finished
	assign busy_fall = busy_d & ~i_tx_busy;

	//////////////////////////////
	// Pacing FSM
	//////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			state      <= uart_queue_pkg::Q_IDLE;
			busy_d     <= 1'b0;
			o_fifo_pop <= 1'b0;
			o_tx_start <= 1'b0;
		end else begin
			busy_d     <= i_tx_busy;
			o_fifo_pop <= 1'b0;	// Strobes last one cycle
			o_tx_start <= 1'b0;
			case (state)
				uart_queue_pkg::Q_IDLE: begin
					// Data waiting, kick off a frame
					if (!i_fifo_empty) begin
						o_fifo_pop <= 1'b1;
						o_tx_start <= 1'b1;
						state      <= uart_queue_pkg::Q_WAIT;
					end
				end
				uart_queue_pkg::Q_WAIT: begin
					if (busy_fall)
						state <= uart_queue_pkg::Q_DONE;
				end
				uart_queue_pkg::Q_DONE: state <= uart_queue_pkg::Q_IDLE;	// Spacer
				default: state <= uart_queue_pkg::Q_IDLE;
			endcase
		end
	end

	// Byte captured together with the start strobe
	always_ff @(posedge i_sys_clk) begin
		if (state == uart_queue_pkg::Q_IDLE && !i_fifo_empty)
			o_tx_data <= i_fifo_data;
	end

endmodule

//--- source/uart_tx_serializer.sv
module uart_tx_serializer (
	input  logic                  i_sys_clk,
	input  logic                  i_reset_n,

	input  logic                  i_start,		// One-cycle frame request
	input  logic [7:0]            i_data,
	input  logic [15:0]           i_baud_div,	// Clocks per bit
	input  uart_line_pkg::parity_e i_parity,
	input  logic                  i_two_stop,

	output logic                  o_tx_line,
	output logic                  o_tx_busy
);

	uart_line_pkg::ser_state_e state;

	// Frame settings, frozen for the whole frame
	logic [7:0]             shift_q;
	logic [15:0]            div_q;
	uart_line_pkg::parity_e par_mode_q;
	logic                   par_bit_q;
	logic                   two_stop_q;

	logic [15:0] baud_cnt;	// Clocks within current bit
	logic [2:0]  bit_cnt;	// Data bit number
	logic        stop_cnt;	// Second stop bit in progress
	logic        bit_end;
	logic        take;

	assign bit_end = (baud_cnt == div_q - 16'd1);
	assign take    = (state == uart_line_pkg::SER_IDLE) & i_start;

	//////////////////////////////
	// Frame latch and shifter
	//////////////////////////////

	always_ff @(posedge i_sys_clk) begin
		if (take) begin
			shift_q    <= i_data;
			div_q      <= i_baud_div;
			par_mode_q <= i_parity;
			two_stop_q <= i_two_stop;
			// Even -> XOR of data, odd -> its inverse
			par_bit_q  <= (i_parity == uart_line_pkg::PARITY_ODD) ? ~^i_data : ^i_data;
		end else if (state == uart_line_pkg::SER_DATA && bit_end) begin
			shift_q <= shift_q >> 1;	// Next bit into position 0
		end
	end

	//////////////////////////////
	// Bit sequencer
	//////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			state     <= uart_line_pkg::SER_IDLE;
			o_tx_line <= 1'b1;	// Idle line is high
			o_tx_busy <= 1'b0;
			baud_cnt  <= 16'd0;
			bit_cnt   <= 3'd0;
			stop_cnt  <= 1'b0;
		end else if (state == uart_line_pkg::SER_IDLE) begin
			baud_cnt <= 16'd0;
			if (i_start) begin
				state     <= uart_line_pkg::SER_START;
				o_tx_line <= 1'b0;	// Start bit
				o_tx_busy <= 1'b1;
			end
		end else if (!bit_end) begin
			baud_cnt <= baud_cnt + 16'd1;
		end else begin
			baud_cnt <= 16'd0;	// New bit
			case (state)
				uart_line_pkg::SER_START: begin
					state     <= uart_line_pkg::SER_DATA;
					o_tx_line <= shift_q[0];	// LSB first
					bit_cnt   <= 3'd0;
				end
				uart_line_pkg::SER_DATA: begin
					if (bit_cnt != 3'd7) begin
						bit_cnt   <= bit_cnt + 3'd1;
						o_tx_line <= shift_q[1];	// Shifter moves on this edge
					end else if (par_mode_q != uart_line_pkg::PARITY_NONE) begin
						state     <= uart_line_pkg::SER_PARITY;
						o_tx_line <= par_bit_q;
					end else begin
						state     <= uart_line_pkg::SER_STOP;
						o_tx_line <= 1'b1;
						stop_cnt  <= 1'b0;
					end
				end
				uart_line_pkg::SER_PARITY: begin
					state     <= uart_line_pkg::SER_STOP;
					o_tx_line <= 1'b1;
					stop_cnt  <= 1'b0;
				end
				uart_line_pkg::SER_STOP: begin
					// Second stop bit only when asked for
					if (two_stop_q && !stop_cnt) begin
						stop_cnt <= 1'b1;
					end else begin
						state     <= uart_line_pkg::SER_IDLE;
						o_tx_busy <= 1'b0;
					end
				end
				default: begin
					state     <= uart_line_pkg::SER_IDLE;
					o_tx_line <= 1'b1;
					o_tx_busy <= 1'b0;
				end
			endcase
		end
	end

endmodule

//--- source/uart_tx_cfg.sv
module uart_tx_cfg (
	input  logic                    i_sys_clk,
	input  logic                    i_reset_n,

	input  logic                    i_cfg_wr,	// Config write strobe
	input  uart_queue_pkg::cfg_op_e i_cfg_op,
	input  logic [31:0]             i_cfg_data,

	output logic [15:0]             o_baud_div,
	output uart_line_pkg::parity_e  o_parity,
	output logic                    o_two_stop,
	output logic                    o_flush		// One-cycle FIFO flush
);

	logic [15:0] div_new;

	// Clamp tiny divisors so every bit has some width
	assign div_new = (i_cfg_data[15:0] < uart_line_pkg::MIN_DIV) ?
		uart_line_pkg::MIN_DIV : i_cfg_data[15:0];

	//////////////////////////////
	// Registers and flush pulse
	//////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			o_baud_div <= uart_line_pkg::DEFAULT_DIV;
			o_parity   <= uart_line_pkg::PARITY_NONE;	// 8N1 after reset
			o_two_stop <= 1'b0;
			o_flush    <= 1'b0;
		end else begin
			o_flush <= 1'b0;
			if (i_cfg_wr) begin
				case (i_cfg_op)
					uart_queue_pkg::CFG_BAUD_DIV: o_baud_div <= div_new;
					uart_queue_pkg::CFG_FRAME: begin
						o_parity   <= uart_line_pkg::parity_e'(i_cfg_data[1:0]);
						o_two_stop <= i_cfg_data[2];
					end
					uart_queue_pkg::CFG_FLUSH: o_flush <= 1'b1;
					default: ;	// Unused opcode, ignored
				endcase
			end
		end
	end

endmodule

//--- source/uart_tx_top.sv
module uart_tx_top (
	input  logic                    i_sys_clk,
	input  logic                    i_reset_n,

	input  logic                    i_word_valid,	// Host word strobe
	input  logic [31:0]             i_word_data,

	input  logic                    i_cfg_wr,
	input  uart_queue_pkg::cfg_op_e i_cfg_op,
	input  logic [31:0]             i_cfg_data,

	output logic                    o_tx_line,
	output logic                    o_tx_busy,
	output logic                    o_fifo_pfull,
	output logic                    o_overflow
);

	localparam int FIFO_WORDS  = 8;
	localparam int PFULL_WORDS = 6;

	logic [15:0]            baud_div;
	uart_line_pkg::parity_e parity;
	logic                   two_stop;
	logic                   flush;

	logic                   fifo_empty;
	logic [7:0]             fifo_data;
	logic                   fifo_pop;
	logic                   tx_start;
	logic [7:0]             tx_data;

	//////////////////////////////
	// Config, FIFO, pacing, line
	//////////////////////////////

	uart_tx_cfg i_uart_tx_cfg (
		.i_sys_clk  (i_sys_clk),
		.i_reset_n  (i_reset_n),
		.i_cfg_wr   (i_cfg_wr),
		.i_cfg_op   (i_cfg_op),
		.i_cfg_data (i_cfg_data),
		.o_baud_div (baud_div),
		.o_parity   (parity),
		.o_two_stop (two_stop),
		.o_flush    (flush)
	);

	// 32-bit in, 8-bit out
	word_byte_fifo #(
		.FIFO_WORDS  (FIFO_WORDS),
		.PFULL_WORDS (PFULL_WORDS)
	) i_word_byte_fifo (
		.i_sys_clk  (i_sys_clk),
		.i_reset_n  (i_reset_n),
		.i_wr       (i_word_valid),
		.i_wr_data  (i_word_data),
		.i_rd       (fifo_pop),
		.i_flush    (flush),
		.o_rd_data  (fifo_data),
		.o_empty    (fifo_empty),
		.o_pfull    (o_fifo_pfull),
		.o_overflow (o_overflow)
	);

	uart_tx_queue i_uart_tx_queue (
		.i_sys_clk    (i_sys_clk),
		.i_reset_n    (i_reset_n),
		.i_fifo_empty (fifo_empty),
		.i_fifo_data  (fifo_data),
		.i_tx_busy    (o_tx_busy),
		.o_fifo_pop   (fifo_pop),
		.o_tx_start   (tx_start),
		.o_tx_data    (tx_data)
	);

	uart_tx_serializer i_uart_tx_serializer (
		.i_sys_clk  (i_sys_clk),
		.i_reset_n  (i_reset_n),
		.i_start    (tx_start),
		.i_data     (tx_data),
		.i_baud_div (baud_div),
		.i_parity   (parity),
		.i_two_stop (two_stop),
		.o_tx_line  (o_tx_line),
		.o_tx_busy  (o_tx_busy)
	);

endmodule

//--- bench/tb_clock.sv
module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 4
)(
	output logic o_sys_clk,
	output logic o_reset_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		o_sys_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_sys_clk = ~o_sys_clk;
	end

	// Reset held low for a fixed number of rising edges
	initial begin
		o_reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_sys_clk);
		o_reset_n <= 1'b1;
	end

endmodule

//--- bench/uart_tx_chk.sv
module uart_tx_chk (
	input logic i_sys_clk,
	input logic i_reset_n,
	input logic i_tx_line,
	input logic i_tx_busy,
	input logic i_tx_start,	// Queue to serializer
	input logic i_fifo_pop,
	input logic i_fifo_empty
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0;	// Failed assertions so far

	//////////////////////////////
	// Line and handshake rules
	//////////////////////////////

	// Idle line is always high
	line_idle_high: assert property (
		@(posedge i_sys_clk) disable iff (!i_reset_n)
		!i_tx_busy |-> i_tx_line
	) else begin
		$error("Serial line low while serializer idle");
		fail_cnt++;
	end

	// No new frame over a running one
	start_when_idle: assert property (
		@(posedge i_sys_clk) disable iff (!i_reset_n)
		i_tx_start |-> !i_tx_busy
	) else begin
		$error("Start strobe while serializer busy");
		fail_cnt++;
	end

	// Pop needs data
	pop_not_empty: assert property (
		@(posedge i_sys_clk) disable iff (!i_reset_n)
		i_fifo_pop |-> !i_fifo_empty
	) else begin
		$error("FIFO popped while empty");
		fail_cnt++;
	end

endmodule

//--- bench/uart_tx_monitor.sv
module uart_tx_monitor (
	input logic                    i_sys_clk,
	input logic                    i_reset_n,
	input logic                    i_cfg_wr,
	input uart_queue_pkg::cfg_op_e i_cfg_op,
	input logic [31:0]             i_cfg_data,
	input logic                    i_tx_line,
	input logic                    i_tx_busy,
	input logic                    i_fifo_pfull,
	input logic                    i_overflow
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] exp_q [$];	// Bytes still owed by the DUT
	int         pending = 0;
	string      cur_name = "none";
	int         test_errs = 0;
	int         err_total = 0;
	int         tests_pass = 0;
	int         tests_fail = 0;
	bit         first_test = 1'b1;
	bit         pfull_seen = 1'b0;
	int         ovf_cnt = 0;

	// Frame format as the DUT should hold it
	int                     cur_div;
	uart_line_pkg::parity_e cur_par;
	bit                     cur_two;

	//////////////////////////////
	// Test bookkeeping
	//////////////////////////////

	task automatic report_value(input string what, input int exp, input int act);
		$display("Fail %s %s expected %0h actual %0h", cur_name, what, exp, act);
		test_errs++;
		err_total++;
	endtask

	task automatic report_text(input string what);
		$display("Error in %s: %s", cur_name, what);
		test_errs++;
		err_total++;
	endtask

	task automatic expect_byte(input logic [7:0] b);
		exp_q.push_back(b);
		pending = exp_q.size();
	endtask

	task automatic start_test(input string name);
		cur_name   = name;
		test_errs  = 0;
		pfull_seen = 1'b0;
		ovf_cnt    = 0;
		// Idle levels right after reset
		if (first_test) begin
			if (i_tx_line !== 1'b1)
				report_value("line after reset", 1, int'(i_tx_line));
			if (i_tx_busy !== 1'b0)
				report_value("busy after reset", 0, int'(i_tx_busy));
			if (i_fifo_pfull !== 1'b0)
				report_value("pfull after reset", 0, int'(i_fifo_pfull));
			first_test = 1'b0;
		end
	endtask

	task automatic finish_test(input bit exp_pfull, input int exp_ovf);
		if (pfull_seen != exp_pfull)
			report_value("pfull seen", int'(exp_pfull), int'(pfull_seen));
		if (ovf_cnt != exp_ovf)
			report_value("overflow pulses", exp_ovf, ovf_cnt);
		if (exp_q.size() != 0) begin
			report_text($sformatf("%0d expected bytes never left the line", exp_q.size()));
			exp_q.delete();
			pending = 0;
		end
		if (test_errs == 0) begin
			$display("Pass %s", cur_name);
			tests_pass++;
		end else begin
			$display("Done %s with %0d errors", cur_name, test_errs);
			tests_fail++;
		end
	endtask

	//////////////////////////////
	// Config and flag tracking
	//////////////////////////////

	always @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			cur_div <= int'(uart_line_pkg::DEFAULT_DIV);
			cur_par <= uart_line_pkg::PARITY_NONE;
			cur_two <= 1'b0;
		end else if (i_cfg_wr) begin
			case (i_cfg_op)
				uart_queue_pkg::CFG_BAUD_DIV:
					cur_div <= (i_cfg_data[15:0] < 16'd4) ? 4 : int'(i_cfg_data[15:0]);	// Clamp
				uart_queue_pkg::CFG_FRAME: begin
					cur_par <= uart_line_pkg::parity_e'(i_cfg_data[1:0]);
					cur_two <= i_cfg_data[2];
				end
				default: ;
			endcase
		end
	end

	always @(posedge i_sys_clk) begin
		if (i_reset_n && i_overflow)
			ovf_cnt++;
		if (i_reset_n && i_fifo_pfull)
			pfull_seen = 1'b1;
	end

	//////////////////////////////
	// Line decoder
	//////////////////////////////

	// Entered on the first sample with the start bit low
	task automatic decode_frame();
		int         div;
		int         nbits;
		int         n;
		int         k;
		int         ones;
		bit         par_on;
		bit         par_odd;
		logic [7:0] data;
		logic       pbit;
		logic       exp_p;
		div     = cur_div;
		par_on  = (cur_par != uart_line_pkg::PARITY_NONE);
		par_odd = (cur_par == uart_line_pkg::PARITY_ODD);
		nbits   = 10 + (par_on ? 1 : 0) + (cur_two ? 1 : 0);
		n       = 0;
		data    = '0;
		pbit    = 1'b0;
		forever begin
			// Bit centre
			if (n % div == div / 2) begin
				k = n / div;
				if (k == 0) begin
					if (i_tx_line !== 1'b0)
						report_value("start bit", 0, int'(i_tx_line));
				end else if (k <= 8) begin
					data[k-1] = i_tx_line;	// LSB first
				end else if (k == 9 && par_on) begin
					pbit = i_tx_line;
				end else if (i_tx_line !== 1'b1) begin
					report_value("stop bit", 1, int'(i_tx_line));
				end
			end
			if (n > 0 && !i_tx_busy)
				break;
			if (n > div * nbits + 2) begin
				report_text("serializer stayed busy past the frame end");
				break;
			end
			@(posedge i_sys_clk);
			n++;
		end
		// Frame length covers bit width and stop count
		if (n < div * nbits - 1 || n > div * nbits + 1)
			report_value("frame clocks", div * nbits, n);
		if (exp_q.size() == 0) begin
			report_text($sformatf("unexpected byte %0h on the line", data));
		end else begin
			if (exp_q[0] !== data)
				report_value("byte", int'(exp_q[0]), int'(data));
			// Ones count including the parity bit is even or odd by mode
			if (par_on) begin
				ones  = $countones(exp_q[0]);
				exp_p = par_odd ? (ones % 2 == 0) : (ones % 2 == 1);
				if (pbit !== exp_p)
					report_value("parity bit", int'(exp_p), int'(pbit));
			end
			void'(exp_q.pop_front());
		end
		pending = exp_q.size();
	endtask

	initial begin
		forever begin
			@(posedge i_sys_clk);
			if (i_reset_n && i_tx_line === 1'b0)
				decode_frame();
		end
	end

endmodule

//--- bench/uart_tx_tb.sv
module uart_tx_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FIFO_WORDS  = 8;
	localparam int IDLE_CYCLES = 64;	// Quiet line that ends a test
	localparam int TIMEOUT     = 200000;
	localparam int NROWS       = 13;

	typedef enum {ACT_CFG, ACT_WORD, ACT_BURST, ACT_FLUSH} act_e;

	typedef struct {
		string                   name;
		act_e                    act;
		uart_queue_pkg::cfg_op_e op;
		logic [31:0]             data;
		int                      count;		// Words in a burst
		bit                      exp_pfull;
		int                      exp_ovf;
	} row_t;

	row_t rows [NROWS];

	logic                    sys_clk;
	logic                    reset_n;
	logic                    word_valid;
	logic [31:0]             word_data;
	logic                    cfg_wr;
	uart_queue_pkg::cfg_op_e cfg_op;
	logic [31:0]             cfg_data;
	logic                    tx_line;
	logic                    tx_busy;
	logic                    fifo_pfull;
	logic                    overflow;
	bit                      timed_out;

	tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(4)) clk_gen (
		.o_sys_clk (sys_clk),
		.o_reset_n (reset_n)
	);

	uart_tx_top i_uart_tx_top (
		.i_sys_clk    (sys_clk),
		.i_reset_n    (reset_n),
		.i_word_valid (word_valid),
		.i_word_data  (word_data),
		.i_cfg_wr     (cfg_wr),
		.i_cfg_op     (cfg_op),
		.i_cfg_data   (cfg_data),
		.o_tx_line    (tx_line),
		.o_tx_busy    (tx_busy),
		.o_fifo_pfull (fifo_pfull),
		.o_overflow   (overflow)
	);

	uart_tx_monitor mon (
		.i_sys_clk    (sys_clk),
		.i_reset_n    (reset_n),
		.i_cfg_wr     (cfg_wr),
		.i_cfg_op     (cfg_op),
		.i_cfg_data   (cfg_data),
		.i_tx_line    (tx_line),
		.i_tx_busy    (tx_busy),
		.i_fifo_pfull (fifo_pfull),
		.i_overflow   (overflow)
	);

	bind uart_tx_top uart_tx_chk i_uart_tx_chk (
		.i_sys_clk    (i_sys_clk),
		.i_reset_n    (i_reset_n),
		.i_tx_line    (o_tx_line),
		.i_tx_busy    (o_tx_busy),
		.i_tx_start   (tx_start),
		.i_fifo_pop   (fifo_pop),
		.i_fifo_empty (fifo_empty)
	);

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	task automatic add_row(input int idx, input string name, input act_e act,
			input uart_queue_pkg::cfg_op_e op, input logic [31:0] data,
			input int count, input bit exp_pfull, input int exp_ovf);
		rows[idx].name      = name;
		rows[idx].act       = act;
		rows[idx].op        = op;
		rows[idx].data      = data;
		rows[idx].count     = count;
		rows[idx].exp_pfull = exp_pfull;
		rows[idx].exp_ovf   = exp_ovf;
	endtask

	task automatic fill_rows();
		add_row(0, "reset_8n1_word", ACT_WORD, uart_queue_pkg::CFG_FRAME, 32'hA5C3_1E80, 1, 0, 0);
		add_row(1, "cfg_even", ACT_CFG, uart_queue_pkg::CFG_FRAME, 32'h1, 0, 0, 0);
		add_row(2, "even_word", ACT_WORD, uart_queue_pkg::CFG_FRAME, 32'h0107_7F96, 1, 0, 0);
		add_row(3, "cfg_odd", ACT_CFG, uart_queue_pkg::CFG_FRAME, 32'h2, 0, 0, 0);
		add_row(4, "odd_word", ACT_WORD, uart_queue_pkg::CFG_FRAME, 32'hFE00_3C71, 1, 0, 0);
		add_row(5, "cfg_div37", ACT_CFG, uart_queue_pkg::CFG_BAUD_DIV, 32'd37, 0, 0, 0);
		add_row(6, "cfg_two_stop", ACT_CFG, uart_queue_pkg::CFG_FRAME, 32'h4, 0, 0, 0);
		add_row(7, "div37_two_stop", ACT_WORD, uart_queue_pkg::CFG_FRAME, 32'h55AA_F00F, 1, 0, 0);
		add_row(8, "cfg_div_clamp", ACT_CFG, uart_queue_pkg::CFG_BAUD_DIV, 32'd2, 0, 0, 0);
		add_row(9, "cfg_8n1", ACT_CFG, uart_queue_pkg::CFG_FRAME, 32'h0, 0, 0, 0);
		add_row(10, "burst_overflow", ACT_BURST, uart_queue_pkg::CFG_FRAME, 32'h0, 10, 1, 2);
		add_row(11, "flush_burst", ACT_FLUSH, uart_queue_pkg::CFG_FLUSH, 32'h0, 4, 0, 0);
		add_row(12, "word_after_flush", ACT_WORD, uart_queue_pkg::CFG_FRAME, 32'h1234_5678, 1, 0, 0);
	endtask

	//////////////////////////////
	// Drivers
	//////////////////////////////

	task automatic write_cfg(input uart_queue_pkg::cfg_op_e op, input logic [31:0] d);
		@(posedge sys_clk);
		cfg_wr   <= 1'b1;
		cfg_op   <= op;
		cfg_data <= d;
		@(posedge sys_clk);
		cfg_wr   <= 1'b0;
	endtask

	// Back-to-back words, bytes owed low first for accepted ones
	task automatic write_words(input int n, input bit rand_data, input logic [31:0] d,
			input bit first_byte_only);
		logic [31:0] w;
		for (int i = 0; i < n; i++) begin
			w = rand_data ? $urandom() : d;
			if (i < FIFO_WORDS && (!first_byte_only || i == 0)) begin
				for (int b = 0; b < 4; b++) begin
					if (!first_byte_only || b == 0)
						mon.expect_byte(w[8*b +: 8]);
				end
			end
			@(posedge sys_clk);
			word_valid <= 1'b1;
			word_data  <= w;
		end
		@(posedge sys_clk);
		word_valid <= 1'b0;
	endtask

	task automatic wait_busy(output bit ok);
		int n;
		n  = 0;
		ok = 1'b1;
		while (tx_busy !== 1'b1) begin
			@(posedge sys_clk);
			n++;
			if (n > TIMEOUT) begin
				ok = 1'b0;
				break;
			end
		end
	endtask

	// Quiet line with nothing owed
	task automatic wait_idle(output bit ok);
		int idle;
		int n;
		idle = 0;
		n    = 0;
		ok   = 1'b1;
		while (idle < IDLE_CYCLES) begin
			@(posedge sys_clk);
			n++;
			if (mon.pending == 0 && tx_busy === 1'b0 && tx_line === 1'b1)
				idle++;
			else
				idle = 0;
			if (n > TIMEOUT) begin
				ok = 1'b0;
				break;
			end
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int n;
		bit ok;
		word_valid = 1'b0;
		word_data  = '0;
		cfg_wr     = 1'b0;
		cfg_op     = uart_queue_pkg::CFG_BAUD_DIV;
		cfg_data   = '0;
		timed_out  = 1'b0;
		void'($urandom(32'h27d4));
		fill_rows();
		n = 0;
		while (reset_n !== 1'b1) begin
			@(posedge sys_clk);
			n++;
			if (n > 100) begin
				$display("Timeout: reset never released");
				timed_out = 1'b1;
				break;
			end
		end
		@(posedge sys_clk);
		for (int r = 0; r < NROWS && !timed_out; r++) begin
			mon.start_test(rows[r].name);
			ok = 1'b1;
			case (rows[r].act)
				ACT_CFG:   write_cfg(rows[r].op, rows[r].data);
				ACT_WORD:  write_words(1, 1'b0, rows[r].data, 1'b0);
				ACT_BURST: write_words(rows[r].count, 1'b1, '0, 1'b0);
				ACT_FLUSH: begin
					// Flush once the first frame is on the line
					write_words(rows[r].count, 1'b1, '0, 1'b1);
					wait_busy(ok);
					if (ok)
						write_cfg(uart_queue_pkg::CFG_FLUSH, '0);
				end
				default: ;
			endcase
			if (ok)
				wait_idle(ok);
			if (!ok) begin
				$display("Timeout: DUT did not finish test %s", rows[r].name);
				timed_out = 1'b1;
			end else begin
				mon.finish_test(rows[r].exp_pfull, rows[r].exp_ovf);
			end
		end
		$display("Tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
			mon.tests_pass, mon.tests_fail, mon.err_total,
			i_uart_tx_top.i_uart_tx_chk.fail_cnt);
		if (timed_out || mon.err_total != 0 ||
				i_uart_tx_top.i_uart_tx_chk.fail_cnt != 0) begin
			$display("Checks failed");
		end else begin
			$display("All checks passed");
		end
		$finish;
	end

endmodule

//--- sources.f
source/uart_line_pkg.sv
source/uart_queue_pkg.sv
source/word_byte_fifo.sv
source/uart_tx_queue.sv
source/uart_tx_serializer.sv
source/uart_tx_cfg.sv
source/uart_tx_top.sv
bench/tb_clock.sv
bench/uart_tx_chk.sv
bench/uart_tx_monitor.sv
bench/uart_tx_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = uart_tx_tb
FILELIST  = sources.f
BUILD     = obj_dir
LOG       = sim.log
PASS_TEXT = All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
